// ==== Makefile ====
# Verilator simulation of the 10GBASE-R receive PCS

VERILATOR ?= verilator
TOP       ?= pcs_rx_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
verilog/code_defs_pkg.sv
verilog/pcs_types_pkg.sv
verilog/rx_block_lock.sv
verilog/rx_descrambler.sv
verilog/decode_6466b.sv
verilog/pcs_rx_top.sv
verification/pcs_rx_tb.sv

// ==== verification/pcs_rx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_tb;

    import pcs_types_pkg::*;
    import code_defs_pkg::*;

    localparam int          MAX_CYCLES = 4000;
    localparam logic [71:0] ERR_COL    = {8'hFF, {8{RS_ERROR}}};
    localparam block_type_t TERM_TYPES [8] = '{BT_T0, BT_T1, BT_T2, BT_T3,
                                               BT_T4, BT_T5, BT_T6, BT_T7};

    logic       i_rxc;
    logic       i_reset;
    logic       i_rx_valid;
    blk_data_t  i_rxd;
    sync_hdr_t  i_rx_header;
    logic       o_slip;
    logic       o_block_lock;
    logic       o_rx_valid;
    blk_data_t  o_rxd;
    xgmii_ctl_t o_rxctl;

    // expected {ctl, data} in output order
    logic [71:0] exp_q[$];
    logic [57:0] scr_sr;
    string       cur_test;
    int          cycle_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          test_fails = 0;
    int          slips_seen = 0;
    int          slips_exp = 0;
    logic        prev_slip = 1'b0;

    // reference lock state, advanced once per sent block
    logic m_locked;
    int   m_good;
    int   m_wait;
    int   m_window;
    int   m_bad;

    always #5 i_rxc = ~i_rxc;

    pcs_rx_top pcs_rx_top_i (
        .i_rxc        (i_rxc),
        .i_reset      (i_reset),
        .i_rx_valid   (i_rx_valid),
        .i_rxd        (i_rxd),
        .i_rx_header  (i_rx_header),
        .o_slip       (o_slip),
        .o_block_lock (o_block_lock),
        .o_rx_valid   (o_rx_valid),
        .o_rxd        (o_rxd),
        .o_rxctl      (o_rxctl)
    );

    task automatic check_value(input string name, input logic [71:0] exp,
                               input logic [71:0] act);
        if (exp === act) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // serial scrambler, sr[0] is the newest line bit
    function automatic blk_data_t scramble(input blk_data_t d);
        blk_data_t s;
        for (int i = 0; i < 64; i++) begin
            s[i]   = d[i] ^ scr_sr[38] ^ scr_sr[57];
            scr_sr = {scr_sr[56:0], s[i]};
        end
        return s;
    endfunction

    function automatic void lock_model(input logic hdr_ok);
        if (!m_locked) begin
            if (m_wait > 0) begin
                m_wait--;
            end else if (!hdr_ok) begin
                m_good = 0;
                m_wait = SLIP_WAIT_BLOCKS;
                slips_exp++;
            end else begin
                m_good++;
                if (m_good == LOCK_GOOD_COUNT) begin
                    m_locked = 1'b1;
                    m_window = 0;
                    m_bad    = 0;
                end
            end
        end else begin
            if (!hdr_ok) begin
                m_bad++;
            end
            if (m_bad == UNLOCK_BAD_COUNT) begin
                m_locked = 1'b0;
                m_good   = 0;
            end else begin
                m_window++;
                if (m_window == UNLOCK_WINDOW) begin
                    m_window = 0;
                    m_bad    = 0;
                end
            end
        end
    endfunction

    task automatic send_block(input sync_hdr_t hdr, input blk_data_t payload,
                              input blk_data_t exp_data, input xgmii_ctl_t exp_ctl);
        logic hdr_ok;
        hdr_ok = (hdr == SYNC_DATA) || (hdr == SYNC_CTRL);
        lock_model(hdr_ok);
        if (m_locked && hdr_ok) begin
            exp_q.push_back({exp_ctl, exp_data});
        end else begin
            exp_q.push_back(ERR_COL);
        end
        @(posedge i_rxc);
        i_rx_valid  <= 1'b1;
        i_rx_header <= hdr;
        i_rxd       <= scramble(payload);
    endtask

    task automatic send_idle();
        send_block(SYNC_CTRL, {56'h0, BT_IDLE}, {8{RS_IDLE}}, 8'hFF);
    endtask

    task automatic send_data(input blk_data_t d);
        send_block(SYNC_DATA, d, d, 8'h00);
    endtask

    task automatic send_bad(input sync_hdr_t hdr);
        send_block(hdr, {56'h0, BT_IDLE}, {8{RS_ERROR}}, 8'hFF);
    endtask

    // data bytes ahead of the terminate lane, idle codes after it
    task automatic send_term(input int n);
        blk_data_t d;
        blk_data_t payload;
        blk_data_t exp;
        d       = {$urandom, $urandom};
        payload = '0;
        exp     = {8{RS_IDLE}};
        for (int i = 0; i < n; i++) begin
            payload[8 + 8*i +: 8] = d[8*i +: 8];
            exp[8*i +: 8]         = d[8*i +: 8];
        end
        payload[7:0]  = TERM_TYPES[n];
        exp[8*n +: 8] = RS_TERM;
        send_block(SYNC_CTRL, payload, exp, xgmii_ctl_t'(8'hFF << n));
    endtask

    task automatic pause();
        @(posedge i_rxc);
        i_rx_valid <= 1'b0;
        @(negedge i_rxc);
    endtask

    task automatic check_lock(input string name, input logic exp);
        check_value(name, 72'(exp), 72'(o_block_lock));
    endtask

    task automatic acquire_lock();
        while (!m_locked) begin
            send_idle();
        end
    endtask

    task automatic apply_reset();
        @(posedge i_rxc);
        i_reset    <= 1'b1;
        i_rx_valid <= 1'b0;
        repeat (10) @(posedge i_rxc);
        i_reset  <= 1'b0;
        scr_sr   = '0;
        m_locked = 1'b0;
        m_good   = 0;
        m_wait   = 0;
        m_window = 0;
        m_bad    = 0;
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_fails = fail_cnt;
    endtask

    // two clocks of latency through the pipe, then nothing may be pending
    task automatic finish_test();
        pause();
        repeat (2) @(negedge i_rxc);
        if (exp_q.size() != 0) begin
            fail_cnt++;
            $display("%s: %0d expected words never came out", cur_test, exp_q.size());
            exp_q.delete();
        end
        $display("%s finished with %0d errors", cur_test, fail_cnt - test_fails);
    endtask

    task automatic test_lock_acquire();
        start_test("lock_acquire");
        @(negedge i_rxc);
        check_value("lock_acquire reset flags", 72'(0),
                    72'({o_slip, o_block_lock, o_rx_valid}));
        check_value("lock_acquire reset word", 72'(0), {o_rxctl, o_rxd});
        repeat (LOCK_GOOD_COUNT - 1) send_idle();
        pause();
        check_lock("lock_acquire lock after 63", 1'b0);
        send_idle();
        pause();
        check_lock("lock_acquire lock after 64", 1'b1);
        repeat (4) send_idle();
        finish_test();
    endtask

    task automatic test_slip();
        start_test("slip");
        apply_reset();
        repeat (10) send_idle();
        send_bad(2'b11);
        // lands in the slip wait, so no second pulse
        send_bad(2'b00);
        repeat (20) send_idle();
        send_bad(2'b00);
        while (m_wait > 0) begin
            send_idle();
        end
        repeat (LOCK_GOOD_COUNT - 1) send_idle();
        pause();
        check_lock("slip relock after 63", 1'b0);
        send_idle();
        pause();
        check_lock("slip relock after 64", 1'b1);
        check_value("slip pulse count", 72'(slips_exp), 72'(slips_seen));
        finish_test();
    endtask

    task automatic test_frames();
        blk_data_t d;
        start_test("frame_decode");
        for (int n = 0; n < 8; n++) begin
            d = {$urandom, $urandom};
            send_block(SYNC_CTRL, {d[63:8], BT_S0}, {d[63:8], RS_START}, 8'h01);
            repeat (4) send_data({$urandom, $urandom});
            send_term(n);
            repeat (2) send_idle();
        end
        finish_test();
    endtask

    task automatic test_ordered_sets();
        blk_data_t d;
        blk_data_t p;
        blk_data_t e;
        start_test("ordered_sets");
        d = {$urandom, $urandom};
        send_block(SYNC_CTRL, {28'h0, 4'h0, d[31:8], BT_O0},
                   {{4{RS_IDLE}}, d[31:8], RS_SEQ}, 8'hF1);
        send_block(SYNC_CTRL, {28'h0, 4'h5, d[31:8], BT_O0},
                   {{4{RS_IDLE}}, d[31:8], RS_ERROR}, 8'hF1);
        send_block(SYNC_CTRL, {d[63:40], 4'h0, 28'h0, BT_O4},
                   {d[63:40], RS_SEQ, {4{RS_IDLE}}}, 8'h1F);
        send_block(SYNC_CTRL, {d[63:40], 4'hA, 28'h0, BT_O4},
                   {d[63:40], RS_ERROR, {4{RS_IDLE}}}, 8'h1F);
        send_block(SYNC_CTRL, {d[63:40], 4'h0, 28'h0, BT_S4},
                   {d[63:40], RS_START, {4{RS_IDLE}}}, 8'h1F);
        send_block(SYNC_CTRL, {d[63:40], 4'h0, 4'h0, d[31:8], BT_O0S4},
                   {d[63:40], RS_START, d[31:8], RS_SEQ}, 8'h11);
        send_block(SYNC_CTRL, {d[63:40], 4'h3, 4'h0, d[31:8], BT_O0O4},
                   {d[63:40], RS_ERROR, d[31:8], RS_SEQ}, 8'h11);
        // idle block with an error code in lane 3
        p           = {56'h0, BT_IDLE};
        p[29 +: 7]  = CC_ERROR;
        e           = {8{RS_IDLE}};
        e[24 +: 8]  = RS_ERROR;
        send_block(SYNC_CTRL, p, e, 8'hFF);
        send_idle();
        finish_test();
    endtask

    task automatic test_errors();
        start_test("errors_unlock");
        send_block(SYNC_CTRL, {56'h0, 8'h00}, {8{RS_ERROR}}, 8'hFF);
        pause();
        check_lock("errors_unlock lock held", 1'b1);
        // keep the whole bad run inside one window
        while (m_window > UNLOCK_WINDOW - 2 * UNLOCK_BAD_COUNT) begin
            send_idle();
        end
        for (int i = 0; i < UNLOCK_BAD_COUNT - 1; i++) begin
            send_bad(2'b11);
            send_idle();
        end
        pause();
        check_lock("errors_unlock lock after 15 bad", 1'b1);
        send_bad(2'b00);
        pause();
        check_lock("errors_unlock lock after 16 bad", 1'b0);
        repeat (5) send_idle();
        acquire_lock();
        finish_test();
    endtask

    task automatic test_random();
        start_test("random_traffic");
        for (int i = 0; i < 200; i++) begin
            if ($urandom % 2 == 1) begin
                send_data({$urandom, $urandom});
            end else begin
                send_idle();
            end
        end
        finish_test();
    endtask

    always @(negedge i_rxc) begin
        if (!i_reset && o_rx_valid) begin
            if (exp_q.size() == 0) begin
                fail_cnt++;
                $display("%s: output word came out with none expected", cur_test);
            end else begin
                check_value(cur_test, exp_q.pop_front(), {o_rxctl, o_rxd});
            end
        end
        if (!i_reset && o_slip) begin
            slips_seen++;
            if (prev_slip) begin
                fail_cnt++;
                $display("%s: slip stayed high for two cycles", cur_test);
            end
            if (o_block_lock) begin
                fail_cnt++;
                $display("%s: slip pulsed while block lock was high", cur_test);
            end
        end
        prev_slip = o_slip;
    end

    always @(posedge i_rxc) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped, tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        i_rxc       = 1'b0;
        i_reset     = 1'b1;
        i_rx_valid  = 1'b0;
        i_rxd       = '0;
        i_rx_header = '0;
        void'($urandom(8));
        apply_reset();
        test_lock_acquire();
        test_slip();
        test_frames();
        test_ordered_sets();
        test_errors();
        test_random();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/code_defs_pkg.sv ====
`default_nettype none

package code_defs_pkg;

    // block type field, first byte of a control block
    typedef logic [7:0] block_type_t;

    localparam block_type_t BT_IDLE = 8'h1E;
    localparam block_type_t BT_O4   = 8'h2D;
    localparam block_type_t BT_S4   = 8'h33;
    localparam block_type_t BT_O0S4 = 8'h66;
    localparam block_type_t BT_O0O4 = 8'h55;
    localparam block_type_t BT_S0   = 8'h78;
    localparam block_type_t BT_O0   = 8'h4B;
    localparam block_type_t BT_T0   = 8'h87;
    localparam block_type_t BT_T1   = 8'h99;
    localparam block_type_t BT_T2   = 8'hAA;
    localparam block_type_t BT_T3   = 8'hB4;
    localparam block_type_t BT_T4   = 8'hCC;
    localparam block_type_t BT_T5   = 8'hD2;
    localparam block_type_t BT_T6   = 8'hE1;
    localparam block_type_t BT_T7   = 8'hFF;

    // sync headers
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // 7-bit control codes inside control blocks
    typedef logic [6:0] cc_t;

    localparam cc_t CC_IDLE  = 7'h00;
    localparam cc_t CC_ERROR = 7'h1E;

    // xgmii characters
    typedef logic [7:0] rs_char_t;

    localparam rs_char_t RS_IDLE  = 8'h07;
    localparam rs_char_t RS_START = 8'hFB;
    localparam rs_char_t RS_TERM  = 8'hFD;
    localparam rs_char_t RS_SEQ   = 8'h9C;
    localparam rs_char_t RS_ERROR = 8'hFE;

    // only idle is a legal control code here, the rest decode as error
    function automatic rs_char_t control_to_rs_code(input cc_t code);
        rs_char_t rs;
        rs = (code == CC_IDLE) ? RS_IDLE : RS_ERROR;
        return rs;
    endfunction

    // O code 0 is a sequence ordered set
    function automatic rs_char_t cc_to_rs_ocode(input logic [3:0] ocode);
        rs_char_t rs;
        rs = (ocode == 4'h0) ? RS_SEQ : RS_ERROR;
        return rs;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/decode_6466b.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_6466b (
    input  wire                        i_rxc,
    input  wire                        i_reset,
    input  wire                        i_block_lock,
    input  wire pcs_types_pkg::rx_block_t   i_block,
    output pcs_types_pkg::xgmii_word_t o_word
);

    import pcs_types_pkg::*;
    import code_defs_pkg::*;

    xgmii_word_t next_word;

    // lanes[7-i] set means lane i carries a 7-bit code at bit 8+7*i
    function automatic blk_data_t control_code_to_rs_lane(input blk_data_t idata,
                                                           input logic [7:0] lanes);
        blk_data_t odata;
        odata = {8{RS_ERROR}};
        for (int i = 0; i < 8; i++) begin
            if (lanes[7-i]) begin
                odata[8*i +: 8] = control_to_rs_code(idata[8 + 7*i +: 7]);
            end
        end
        return odata;
    endfunction

    function automatic xgmii_word_t decode_block(input blk_data_t idata,
                                                 input sync_hdr_t ihdr);
        xgmii_word_t w;
        w.valid = 1'b1;
        w.data  = {8{RS_ERROR}};
        w.ctl   = 8'hFF;
        if (ihdr == SYNC_DATA) begin
            w.data = idata;
            w.ctl  = 8'h00;
        end else if (ihdr == SYNC_CTRL) begin
            case (block_type_t'(idata[7:0]))
                BT_IDLE: begin
                    w.data = control_code_to_rs_lane(idata, 8'hFF);
                    w.ctl  = 8'hFF;
                end
                BT_O4: begin
                    w.data        = control_code_to_rs_lane(idata, 8'hF0);
                    w.data[63:40] = idata[63:40];
                    w.data[39:32] = cc_to_rs_ocode(idata[39:36]);
                    w.ctl         = 8'h1F;
                end
                BT_S4: begin
                    w.data        = control_code_to_rs_lane(idata, 8'hF0);
                    w.data[63:40] = idata[63:40];
                    w.data[39:32] = RS_START;
                    w.ctl         = 8'h1F;
                end
                BT_O0S4: begin
                    w.data[63:40] = idata[63:40];
                    w.data[39:32] = RS_START;
                    w.data[31:8]  = idata[31:8];
                    w.data[7:0]   = cc_to_rs_ocode(idata[35:32]);
                    w.ctl         = 8'h11;
                end
                BT_O0O4: begin
                    // O0 sits in bits 35:32, O4 in bits 39:36
                    w.data[63:40] = idata[63:40];
                    w.data[39:32] = cc_to_rs_ocode(idata[39:36]);
                    w.data[31:8]  = idata[31:8];
                    w.data[7:0]   = cc_to_rs_ocode(idata[35:32]);
                    w.ctl         = 8'h11;
                end
                BT_S0: begin
                    w.data[63:8] = idata[63:8];
                    w.data[7:0]  = RS_START;
                    w.ctl        = 8'h01;
                end
                BT_O0: begin
                    w.data       = control_code_to_rs_lane(idata, 8'h0F);
                    w.data[31:8] = idata[31:8];
                    w.data[7:0]  = cc_to_rs_ocode(idata[35:32]);
                    w.ctl        = 8'hF1;
                end
                BT_T0: begin
                    w.data      = control_code_to_rs_lane(idata, 8'h7F);
                    w.data[7:0] = RS_TERM;
                    w.ctl       = 8'hFF;
                end
                BT_T1: begin
                    w.data       = control_code_to_rs_lane(idata, 8'h3F);
                    w.data[7:0]  = idata[15:8];
                    w.data[15:8] = RS_TERM;
                    w.ctl        = 8'hFE;
                end
                BT_T2: begin
                    w.data        = control_code_to_rs_lane(idata, 8'h1F);
                    w.data[15:0]  = idata[23:8];
                    w.data[23:16] = RS_TERM;
                    w.ctl         = 8'hFC;
                end
                BT_T3: begin
                    w.data        = control_code_to_rs_lane(idata, 8'h0F);
                    w.data[23:0]  = idata[31:8];
                    w.data[31:24] = RS_TERM;
                    w.ctl         = 8'hF8;
                end
                BT_T4: begin
                    w.data        = control_code_to_rs_lane(idata, 8'h07);
                    w.data[31:0]  = idata[39:8];
                    w.data[39:32] = RS_TERM;
                    w.ctl         = 8'hF0;
                end
                BT_T5: begin
                    w.data        = control_code_to_rs_lane(idata, 8'h03);
                    w.data[39:0]  = idata[47:8];
                    w.data[47:40] = RS_TERM;
                    w.ctl         = 8'hE0;
                end
                BT_T6: begin
                    w.data        = control_code_to_rs_lane(idata, 8'h01);
                    w.data[47:0]  = idata[55:8];
                    w.data[55:48] = RS_TERM;
                    w.ctl         = 8'hC0;
                end
                BT_T7: begin
                    w.data[55:0]  = idata[63:8];
                    w.data[63:56] = RS_TERM;
                    w.ctl         = 8'h80;
                end
                default: begin
                    // unknown type, error column stays
                    w.ctl = 8'hFF;
                end
            endcase
        end
        return w;
    endfunction

    always_comb begin
        next_word = decode_block(i_block.data, i_block.header);
        // nothing is trusted before block lock
        if (!i_block_lock) begin
            next_word.data = {8{RS_ERROR}};
            next_word.ctl  = 8'hFF;
        end
        next_word.valid = i_block.valid;
    end

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            o_word <= '0;
        end else if (i_block.valid) begin
            o_word <= next_word;
        end else begin
            o_word.valid <= 1'b0;
        end
    end

    a_data_ctl_zero: assert property (@(posedge i_rxc) disable iff (i_reset)
        (i_block.valid && i_block_lock && i_block.header == SYNC_DATA)
        |=> o_word.ctl == '0);

endmodule

`default_nettype wire

// ==== verilog/pcs_rx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_top (
    input  wire                       i_rxc,
    input  wire                       i_reset,
    input  wire                       i_rx_valid,
    input  wire pcs_types_pkg::blk_data_t  i_rxd,
    input  wire pcs_types_pkg::sync_hdr_t  i_rx_header,
    output logic                      o_slip,
    output logic                      o_block_lock,
    output logic                      o_rx_valid,
    output pcs_types_pkg::blk_data_t  o_rxd,
    output pcs_types_pkg::xgmii_ctl_t o_rxctl
);

    import pcs_types_pkg::*;

    rx_block_t   raw_block;
    rx_block_t   descr_block;
    xgmii_word_t xgmii_word;
    logic        block_lock;

    assign raw_block.valid  = i_rx_valid;
    assign raw_block.header = i_rx_header;
    assign raw_block.data   = i_rxd;

    // lock works on the raw headers, alongside the descrambler
    rx_block_lock rx_block_lock_i (
        .i_rxc        (i_rxc),
        .i_reset      (i_reset),
        .i_block      (raw_block),
        .o_block_lock (block_lock),
        .o_slip       (o_slip)
    );

    rx_descrambler rx_descrambler_i (
        .i_rxc   (i_rxc),
        .i_reset (i_reset),
        .i_block (raw_block),
        .o_block (descr_block)
    );

    decode_6466b decode_6466b_i (
        .i_rxc        (i_rxc),
        .i_reset      (i_reset),
        .i_block_lock (block_lock),
        .i_block      (descr_block),
        .o_word       (xgmii_word)
    );

    assign o_block_lock = block_lock;
    assign o_rx_valid   = xgmii_word.valid;
    assign o_rxd        = xgmii_word.data;
    assign o_rxctl      = xgmii_word.ctl;

endmodule

`default_nettype wire

// ==== verilog/pcs_types_pkg.sv ====
`default_nettype none

package pcs_types_pkg;

    // datapath widths
    typedef logic [63:0] blk_data_t;
    typedef logic [1:0]  sync_hdr_t;
    typedef logic [7:0]  xgmii_ctl_t;

    // one 66-bit block plus its strobe
    typedef struct packed {
        logic      valid;
        sync_hdr_t header;
        blk_data_t data;
    } rx_block_t;

    // one xgmii column pair, decoder output
    typedef struct packed {
        logic       valid;
        xgmii_ctl_t ctl;
        blk_data_t  data;
    } xgmii_word_t;

    // block lock thresholds, in valid headers
    localparam int LOCK_GOOD_COUNT  = 64;
    localparam int UNLOCK_BAD_COUNT = 16;
    localparam int UNLOCK_WINDOW    = 64;

    // valid blocks ignored after a slip request
    localparam int SLIP_WAIT_BLOCKS = 2;

endpackage

`default_nettype wire

// ==== verilog/rx_block_lock.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_block_lock (
    input  wire                      i_rxc,
    input  wire                      i_reset,
    input  wire pcs_types_pkg::rx_block_t i_block,
    output logic                     o_block_lock,
    output logic                     o_slip
);

    import pcs_types_pkg::*;

    typedef enum logic [1:0] {
        LOCK_HUNT,
        LOCK_SLIP_WAIT,
        LOCK_LOCKED
    } lock_state_t;

    lock_state_t state;

    logic [$clog2(LOCK_GOOD_COUNT)-1:0]  good_cnt;
    logic [$clog2(UNLOCK_WINDOW)-1:0]    window_cnt;
    logic [$clog2(UNLOCK_BAD_COUNT)-1:0] bad_cnt;
    logic [$clog2(SLIP_WAIT_BLOCKS)-1:0] wait_cnt;
    logic                                hdr_good;

    // 01 and 10 are the only legal headers
    assign hdr_good = ^i_block.header;

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            state        <= LOCK_HUNT;
            good_cnt     <= '0;
            window_cnt   <= '0;
            bad_cnt      <= '0;
            wait_cnt     <= '0;
            o_block_lock <= 1'b0;
            o_slip       <= 1'b0;
        end else begin
            o_slip <= 1'b0;
            if (i_block.valid) begin
                case (state)
                    LOCK_HUNT: begin
                        if (!hdr_good) begin
                            good_cnt <= '0;
                            wait_cnt <= '0;
                            o_slip   <= 1'b1;
                            state    <= LOCK_SLIP_WAIT;
                        end else if (int'(good_cnt) == LOCK_GOOD_COUNT - 1) begin
                            good_cnt     <= '0;
                            window_cnt   <= '0;
                            bad_cnt      <= '0;
                            o_block_lock <= 1'b1;
                            state        <= LOCK_LOCKED;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                    LOCK_SLIP_WAIT: begin
                        // gearbox is shifting, headers here mean nothing
                        if (int'(wait_cnt) == SLIP_WAIT_BLOCKS - 1) begin
                            wait_cnt <= '0;
                            state    <= LOCK_HUNT;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                    LOCK_LOCKED: begin
                        if (!hdr_good && int'(bad_cnt) == UNLOCK_BAD_COUNT - 1) begin
                            o_block_lock <= 1'b0;
                            good_cnt     <= '0;
                            state        <= LOCK_HUNT;
                        end else if (int'(window_cnt) == UNLOCK_WINDOW - 1) begin
                            // window closes, start a fresh bad count
                            window_cnt <= '0;
                            bad_cnt    <= '0;
                        end else begin
                            window_cnt <= window_cnt + 1'b1;
                            if (!hdr_good) begin
                                bad_cnt <= bad_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= LOCK_HUNT;
                    end
                endcase
            end
        end
    end

    // slip only makes sense while hunting
    a_slip_unlocked: assert property (@(posedge i_rxc) disable iff (i_reset)
        $rose(o_slip) |-> !o_block_lock);

    a_slip_single: assert property (@(posedge i_rxc) disable iff (i_reset)
        o_slip |=> !o_slip);

endmodule

`default_nettype wire

// ==== verilog/rx_descrambler.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_descrambler (
    input  wire                      i_rxc,
    input  wire                      i_reset,
    input  wire pcs_types_pkg::rx_block_t i_block,
    output pcs_types_pkg::rx_block_t o_block
);

    import pcs_types_pkg::*;

    // last 58 scrambled bits, bit 57 is the newest
    logic [57:0]  scr_state;
    // scrambled history followed by the current block, 58 + 64 bits
    logic [121:0] hist;
    blk_data_t    descr_data;

    assign hist = {i_block.data, scr_state};

    // x^58 + x^39 + 1, bit 0 is the oldest bit on the line
    always_comb begin
        for (int i = 0; i < 64; i++) begin
            descr_data[i] = hist[i + 58] ^ hist[i + 19] ^ hist[i];
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            scr_state     <= '0;
            o_block.valid <= 1'b0;
        end else begin
            o_block.valid <= i_block.valid;
            if (i_block.valid) begin
                scr_state <= i_block.data[63:6];
            end
        end
    end

    // payload stage, header passes untouched
    always_ff @(posedge i_rxc) begin
        if (i_block.valid) begin
            o_block.header <= i_block.header;
            o_block.data   <= descr_data;
        end
    end

    a_valid_delay: assert property (@(posedge i_rxc) disable iff (i_reset)
        !$past(i_reset) |-> o_block.valid == $past(i_block.valid));

endmodule

`default_nettype wire
